// File: axi_ar_arbiter.sv
`default_nettype none

module axi_ar_arbiter
  import axi_pkg::*;
#(
  parameter int id_bits   = 4,
  parameter int addr_bits = 32
) (
  input  logic clk,
  input  logic rstn,
  ar_if.dst    m0,
  ar_if.dst    m1,
  ar_if.src    out
);

  master_sel_t sel;
  master_sel_t grant;   // Held master while a request waits
  master_sel_t prefer;  // Round-robin pointer
  logic        locked;
  logic        handshake;

  logic [id_bits-1:0]   id_sel;
  logic [addr_bits-1:0] addr_sel;
  logic [7:0]           len_sel;
  logic                 valid_sel;

  always_comb begin
    if (locked) begin
      sel = grant;
    end else if (m0.valid && m1.valid) begin
      sel = prefer;
    end else if (m1.valid) begin
      sel = MASTER_1;
    end else begin
      sel = MASTER_0;
    end
  end

  always_comb begin
    if (sel == MASTER_1) begin
      id_sel    = m1.id;
      addr_sel  = m1.addr;
      len_sel   = m1.len;
      valid_sel = m1.valid;
    end else begin
      id_sel    = m0.id;
      addr_sel  = m0.addr;
      len_sel   = m0.len;
      valid_sel = m0.valid;
    end
  end

  assign out.id    = {sel, id_sel};  // Tag above the master ID
  assign out.addr  = addr_sel;
  assign out.len   = len_sel;
  assign out.valid = valid_sel;

  assign m0.ready = out.ready && (sel == MASTER_0);
  assign m1.ready = out.ready && (sel == MASTER_1);

  assign handshake = out.valid && out.ready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      locked <= 1'b0;
      grant  <= MASTER_0;
      prefer <= MASTER_0;
    end else begin
      if (handshake) begin
        locked <= 1'b0;
        prefer <= (sel == MASTER_0) ? MASTER_1 : MASTER_0;
      end else if (out.valid) begin
        locked <= 1'b1;  // Keep the stalled master
        grant  <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_ar_decoder.sv
`default_nettype none

module axi_ar_decoder
  import axi_pkg::*;
#(
  parameter int id_bits   = 4,
  parameter int addr_bits = 32,
  parameter int max_out   = 2
) (
  input  logic       clk,
  input  logic       rstn,
  ar_if.dst          in,
  ar_if.src          s0,
  ar_if.src          s1,
  ar_if.src          s2,
  input  logic [2:0] done_slave
);

  localparam int cnt_bits = $clog2(max_out + 1);

  logic [id_bits+tag_bits-1:0] id;
  logic [addr_bits-1:0]        addr;
  slave_sel_t                  slv;
  logic [2:0]                  hit;
  logic [2:0]                  full;
  logic [2:0]                  svalid;
  logic [2:0]                  sready;
  logic [2:0]                  inc;

  logic [cnt_bits-1:0] cnt [3];  // Open bursts per slave

  assign id   = in.id;
  assign addr = in.addr;
  assign slv  = region_slave(addr[17:16]);
  assign hit  = slv_onehot(slv);

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      full[i] = (cnt[i] == cnt_bits'(max_out));
    end
  end

  // Full slave sees no valid
  assign svalid = hit & ~full & {3{in.valid}};
  assign sready = {s2.ready, s1.ready, s0.ready};
  assign inc    = svalid & sready;

  assign in.ready = |(hit & ~full & sready);

  assign s0.id    = id;
  assign s0.addr  = addr;
  assign s0.len   = in.len;
  assign s0.valid = svalid[0];

  assign s1.id    = id;
  assign s1.addr  = addr;
  assign s1.len   = in.len;
  assign s1.valid = svalid[1];

  assign s2.id    = id;
  assign s2.addr  = addr;
  assign s2.len   = in.len;
  assign s2.valid = svalid[2];

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // AR handshake and last beat may land together
        cnt[i] <= cnt[i] + cnt_bits'(inc[i]) - cnt_bits'(done_slave[i]);
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_if.sv
`default_nettype none

interface ar_if #(
  parameter int id_bits   = 4,
  parameter int addr_bits = 32
);

  logic [id_bits-1:0]   id;
  logic [addr_bits-1:0] addr;
  logic [7:0]           len;
  logic                 valid;
  logic                 ready;

  modport src(output id, output addr, output len, output valid, input ready);
  modport dst(input id, input addr, input len, input valid, output ready);

endinterface

interface r_if #(
  parameter int id_bits   = 4,
  parameter int data_bits = 32
);

  logic [id_bits-1:0]   id;
  logic [data_bits-1:0] data;
  logic [1:0]           resp;
  logic                 last;
  logic                 valid;
  logic                 ready;

  modport src(
    output id, output data, output resp, output last, output valid,
    input ready
  );
  modport dst(
    input id, input data, input resp, input last, input valid,
    output ready
  );

endinterface

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

  // Master index bits above the master ID
  localparam int tag_bits = 2;

  typedef enum logic [1:0] {
    MASTER_0,
    MASTER_1,
    MASTER_2,
    MASTER_U
  } master_sel_t;

  typedef enum logic [1:0] {
    LOCK_NO,
    LOCK_S0,
    LOCK_S1,
    LOCK_S2
  } lock_t;

  typedef enum logic [1:0] {
    SLV_0,
    SLV_1,
    SLV_2
  } slave_sel_t;

  function automatic logic [2:0] slv_onehot(slave_sel_t s);
    return 3'b001 << s;
  endfunction

  // Region 3 has no slave of its own
  function automatic slave_sel_t region_slave(logic [1:0] region);
    if (region == 2'd3) begin
      return SLV_2;
    end
    return slave_sel_t'(region);
  endfunction

endpackage

`default_nettype wire

// File: axi_r_router.sv
`default_nettype none

module axi_r_router
  import axi_pkg::*;
#(
  parameter int id_bits   = 4,
  parameter int data_bits = 32
) (
  input  logic       clk,
  input  logic       rstn,
  r_if.dst           s0,
  r_if.dst           s1,
  r_if.dst           s2,
  r_if.src           m0,
  r_if.src           m1,
  output logic [2:0] done_slave
);

  localparam int tid_bits = id_bits + tag_bits;

  logic [tid_bits-1:0]  rid   [3];
  logic [data_bits-1:0] rdata [3];
  logic [1:0]           rresp [3];
  logic [2:0]           rlast;
  logic [2:0]           rvalid;
  logic [2:0]           rready;

  lock_t       lock;
  lock_t       lock_next;
  slave_sel_t  cur;
  logic        pick;
  master_sel_t tag;

  logic [tid_bits-1:0]  rid_s;
  logic [data_bits-1:0] rdata_s;
  logic [1:0]           rresp_s;
  logic                 rlast_s;
  logic                 rvalid_s;
  logic                 ready_m;
  logic                 accept;

  assign rid[0]    = s0.id;
  assign rdata[0]  = s0.data;
  assign rresp[0]  = s0.resp;
  assign rid[1]    = s1.id;
  assign rdata[1]  = s1.data;
  assign rresp[1]  = s1.resp;
  assign rid[2]    = s2.id;
  assign rdata[2]  = s2.data;
  assign rresp[2]  = s2.resp;
  assign rlast     = {s2.last, s1.last, s0.last};
  assign rvalid    = {s2.valid, s1.valid, s0.valid};
  assign s0.ready  = rready[0];
  assign s1.ready  = rready[1];
  assign s2.ready  = rready[2];

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

  // Slave select
  always_comb begin
    pick = 1'b1;
    cur  = SLV_0;
    case (lock)
      LOCK_S0: cur = SLV_0;
      LOCK_S1: cur = SLV_1;
      LOCK_S2: cur = SLV_2;
      default: begin
        if (rvalid[0]) cur = SLV_0;  // Fixed priority when free
        else if (rvalid[1]) cur = SLV_1;
        else if (rvalid[2]) cur = SLV_2;
        else pick = 1'b0;
      end
    endcase
  end

  assign rid_s    = rid[cur];
  assign rdata_s  = rdata[cur];
  assign rresp_s  = rresp[cur];
  assign rlast_s  = rlast[cur];
  assign rvalid_s = pick && rvalid[cur];
  assign tag      = master_sel_t'(rid_s[tid_bits-1 -: tag_bits]);

  // Route to the tagged master
  always_comb begin
    m0.id    = '0;
    m0.data  = '0;
    m0.resp  = 2'b00;
    m0.last  = 1'b0;
    m0.valid = 1'b0;
    m1.id    = '0;
    m1.data  = '0;
    m1.resp  = 2'b00;
    m1.last  = 1'b0;
    m1.valid = 1'b0;
    ready_m  = 1'b0;
    case (tag)
      MASTER_0: begin
        m0.id    = rid_s[id_bits-1:0];
        m0.data  = rdata_s;
        m0.resp  = rresp_s;
        m0.last  = rlast_s;
        m0.valid = rvalid_s;
        ready_m  = m0.ready;
      end
      MASTER_1: begin
        m1.id    = rid_s[id_bits-1:0];
        m1.data  = rdata_s;
        m1.resp  = rresp_s;
        m1.last  = rlast_s;
        m1.valid = rvalid_s;
        ready_m  = m1.ready;
      end
      default: ready_m = 1'b0;  // No such master
    endcase
  end

  assign accept     = rvalid_s && ready_m;
  assign rready     = pick ? (slv_onehot(cur) & {3{ready_m}}) : 3'b000;
  assign done_slave = (accept && rlast_s) ? slv_onehot(cur) : 3'b000;

  always_comb begin
    lock_next = lock;
    if (lock == LOCK_NO) begin
      if (rvalid_s && !ready_m) begin
        case (cur)  // Hold the stalled beat
          SLV_0: lock_next = LOCK_S0;
          SLV_1: lock_next = LOCK_S1;
          default: lock_next = LOCK_S2;
        endcase
      end
    end else if (accept) begin
      // Rotate past the slave just served
      case (cur)
        SLV_0: lock_next = rvalid[1] ? LOCK_S1 : (rvalid[2] ? LOCK_S2 : LOCK_NO);
        SLV_1: lock_next = rvalid[2] ? LOCK_S2 : (rvalid[0] ? LOCK_S0 : LOCK_NO);
        default: lock_next = rvalid[0] ? LOCK_S0 : (rvalid[1] ? LOCK_S1 : LOCK_NO);
      endcase
    end
  end

endmodule

`default_nettype wire

// File: axi_read_xbar.f
axi_pkg.sv
axi_if.sv
axi_ar_arbiter.sv
axi_ar_decoder.sv
axi_r_router.sv
axi_read_xbar.sv
tb_axi_read_xbar.sv

// File: axi_read_xbar.sv
`default_nettype none

module axi_read_xbar
  import axi_pkg::*;
#(
  parameter int id_bits   = 4,
  parameter int addr_bits = 32,
  parameter int data_bits = 32,
  parameter int max_out   = 2
) (
  input  logic                        clk,
  input  logic                        rstn,
  // Master 0
  input  logic [id_bits-1:0]          m0_arid,
  input  logic [addr_bits-1:0]        m0_araddr,
  input  logic [7:0]                  m0_arlen,
  input  logic                        m0_arvalid,
  output logic                        m0_arready,
  output logic [id_bits-1:0]          m0_rid,
  output logic [data_bits-1:0]        m0_rdata,
  output logic [1:0]                  m0_rresp,
  output logic                        m0_rlast,
  output logic                        m0_rvalid,
  input  logic                        m0_rready,
  // Master 1
  input  logic [id_bits-1:0]          m1_arid,
  input  logic [addr_bits-1:0]        m1_araddr,
  input  logic [7:0]                  m1_arlen,
  input  logic                        m1_arvalid,
  output logic                        m1_arready,
  output logic [id_bits-1:0]          m1_rid,
  output logic [data_bits-1:0]        m1_rdata,
  output logic [1:0]                  m1_rresp,
  output logic                        m1_rlast,
  output logic                        m1_rvalid,
  input  logic                        m1_rready,
  // Slave 0
  output logic [id_bits+tag_bits-1:0] s0_arid,
  output logic [addr_bits-1:0]        s0_araddr,
  output logic [7:0]                  s0_arlen,
  output logic                        s0_arvalid,
  input  logic                        s0_arready,
  input  logic [id_bits+tag_bits-1:0] s0_rid,
  input  logic [data_bits-1:0]        s0_rdata,
  input  logic [1:0]                  s0_rresp,
  input  logic                        s0_rlast,
  input  logic                        s0_rvalid,
  output logic                        s0_rready,
  // Slave 1
  output logic [id_bits+tag_bits-1:0] s1_arid,
  output logic [addr_bits-1:0]        s1_araddr,
  output logic [7:0]                  s1_arlen,
  output logic                        s1_arvalid,
  input  logic                        s1_arready,
  input  logic [id_bits+tag_bits-1:0] s1_rid,
  input  logic [data_bits-1:0]        s1_rdata,
  input  logic [1:0]                  s1_rresp,
  input  logic                        s1_rlast,
  input  logic                        s1_rvalid,
  output logic                        s1_rready,
  // Slave 2
  output logic [id_bits+tag_bits-1:0] s2_arid,
  output logic [addr_bits-1:0]        s2_araddr,
  output logic [7:0]                  s2_arlen,
  output logic                        s2_arvalid,
  input  logic                        s2_arready,
  input  logic [id_bits+tag_bits-1:0] s2_rid,
  input  logic [data_bits-1:0]        s2_rdata,
  input  logic [1:0]                  s2_rresp,
  input  logic                        s2_rlast,
  input  logic                        s2_rvalid,
  output logic                        s2_rready
);

  logic [2:0] done_slave;

  ar_if #(.id_bits(id_bits), .addr_bits(addr_bits)) ar_m0 ();
  ar_if #(.id_bits(id_bits), .addr_bits(addr_bits)) ar_m1 ();
  ar_if #(.id_bits(id_bits + tag_bits), .addr_bits(addr_bits)) ar_tag ();
  ar_if #(.id_bits(id_bits + tag_bits), .addr_bits(addr_bits)) ar_s0 ();
  ar_if #(.id_bits(id_bits + tag_bits), .addr_bits(addr_bits)) ar_s1 ();
  ar_if #(.id_bits(id_bits + tag_bits), .addr_bits(addr_bits)) ar_s2 ();

  r_if #(.id_bits(id_bits + tag_bits), .data_bits(data_bits)) r_s0 ();
  r_if #(.id_bits(id_bits + tag_bits), .data_bits(data_bits)) r_s1 ();
  r_if #(.id_bits(id_bits + tag_bits), .data_bits(data_bits)) r_s2 ();
  r_if #(.id_bits(id_bits), .data_bits(data_bits)) r_m0 ();
  r_if #(.id_bits(id_bits), .data_bits(data_bits)) r_m1 ();

  // Master AR side
  assign ar_m0.id    = m0_arid;
  assign ar_m0.addr  = m0_araddr;
  assign ar_m0.len   = m0_arlen;
  assign ar_m0.valid = m0_arvalid;
  assign m0_arready  = ar_m0.ready;
  assign ar_m1.id    = m1_arid;
  assign ar_m1.addr  = m1_araddr;
  assign ar_m1.len   = m1_arlen;
  assign ar_m1.valid = m1_arvalid;
  assign m1_arready  = ar_m1.ready;

  // Slave AR side
  assign s0_arid     = ar_s0.id;
  assign s0_araddr   = ar_s0.addr;
  assign s0_arlen    = ar_s0.len;
  assign s0_arvalid  = ar_s0.valid;
  assign ar_s0.ready = s0_arready;
  assign s1_arid     = ar_s1.id;
  assign s1_araddr   = ar_s1.addr;
  assign s1_arlen    = ar_s1.len;
  assign s1_arvalid  = ar_s1.valid;
  assign ar_s1.ready = s1_arready;
  assign s2_arid     = ar_s2.id;
  assign s2_araddr   = ar_s2.addr;
  assign s2_arlen    = ar_s2.len;
  assign s2_arvalid  = ar_s2.valid;
  assign ar_s2.ready = s2_arready;

  // Slave R side
  assign r_s0.id    = s0_rid;
  assign r_s0.data  = s0_rdata;
  assign r_s0.resp  = s0_rresp;
  assign r_s0.last  = s0_rlast;
  assign r_s0.valid = s0_rvalid;
  assign s0_rready  = r_s0.ready;
  assign r_s1.id    = s1_rid;
  assign r_s1.data  = s1_rdata;
  assign r_s1.resp  = s1_rresp;
  assign r_s1.last  = s1_rlast;
  assign r_s1.valid = s1_rvalid;
  assign s1_rready  = r_s1.ready;
  assign r_s2.id    = s2_rid;
  assign r_s2.data  = s2_rdata;
  assign r_s2.resp  = s2_rresp;
  assign r_s2.last  = s2_rlast;
  assign r_s2.valid = s2_rvalid;
  assign s2_rready  = r_s2.ready;

  // Master R side
  assign m0_rid     = r_m0.id;
  assign m0_rdata   = r_m0.data;
  assign m0_rresp   = r_m0.resp;
  assign m0_rlast   = r_m0.last;
  assign m0_rvalid  = r_m0.valid;
  assign r_m0.ready = m0_rready;
  assign m1_rid     = r_m1.id;
  assign m1_rdata   = r_m1.data;
  assign m1_rresp   = r_m1.resp;
  assign m1_rlast   = r_m1.last;
  assign m1_rvalid  = r_m1.valid;
  assign r_m1.ready = m1_rready;

  axi_ar_arbiter #(
    .id_bits  (id_bits),
    .addr_bits(addr_bits)
  ) axi_ar_arbiter_inst (
    .clk (clk),
    .rstn(rstn),
    .m0  (ar_m0),
    .m1  (ar_m1),
    .out (ar_tag)
  );

  axi_ar_decoder #(
    .id_bits  (id_bits),
    .addr_bits(addr_bits),
    .max_out  (max_out)
  ) axi_ar_decoder_inst (
    .clk       (clk),
    .rstn      (rstn),
    .in        (ar_tag),
    .s0        (ar_s0),
    .s1        (ar_s1),
    .s2        (ar_s2),
    .done_slave(done_slave)
  );

  axi_r_router #(
    .id_bits  (id_bits),
    .data_bits(data_bits)
  ) axi_r_router_inst (
    .clk       (clk),
    .rstn      (rstn),
    .s0        (r_s0),
    .s1        (r_s1),
    .s2        (r_s2),
    .m0        (r_m0),
    .m1        (r_m1),
    .done_slave(done_slave)
  );

endmodule

`default_nettype wire

// File: tb_axi_read_xbar.sv
`default_nettype none

module tb_axi_read_xbar
  import axi_pkg::*;
();

  localparam int id_bits     = 4;
  localparam int addr_bits   = 32;
  localparam int data_bits   = 32;
  localparam int max_out     = 2;
  localparam int tid_bits    = id_bits + tag_bits;
  localparam int n_rows      = 12;
  localparam int hold_cycles = 150;  // Slave 0 R held back this long

  typedef struct packed {
    logic        master;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [1:0]  slave;  // Expected slave index
  } row_t;

  logic clk  = 1'b0;
  logic rstn = 1'b0;

  logic [id_bits-1:0]   m_arid    [2];
  logic [addr_bits-1:0] m_araddr  [2];
  logic [7:0]           m_arlen   [2];
  logic                 m_arvalid [2];
  logic                 m_arready [2];
  logic [id_bits-1:0]   m_rid     [2];
  logic [data_bits-1:0] m_rdata   [2];
  logic [1:0]           m_rresp   [2];
  logic                 m_rlast   [2];
  logic                 m_rvalid  [2];
  logic                 m_rready  [2];

  logic [tid_bits-1:0]  s_arid    [3];
  logic [addr_bits-1:0] s_araddr  [3];
  logic [7:0]           s_arlen   [3];
  logic                 s_arvalid [3];
  logic                 s_arready [3];
  logic [tid_bits-1:0]  s_rid     [3];
  logic [data_bits-1:0] s_rdata   [3];
  logic [1:0]           s_rresp   [3];
  logic                 s_rlast   [3];
  logic                 s_rvalid  [3];
  logic                 s_rready  [3];

  row_t        rows [n_rows];
  int          beats_got [n_rows];
  int          total_beats;
  int          beats_done;
  int          mismatches;
  int          failures;
  int          cycle;
  int          limit;
  logic [31:0] rng;

  // Slave model queues of {tagged id, addr, len}
  logic [45:0] fifo [3][16];
  int          wr_ptr   [3];
  int          rd_ptr   [3];
  int          beat_no  [3];
  int          open_cnt [3];
  int          max_open0;
  logic        r_taken  [3];

  logic                 held      [2];
  logic [id_bits-1:0]   held_id   [2];
  logic [data_bits-1:0] held_data [2];

  axi_read_xbar #(
    .id_bits  (id_bits),
    .addr_bits(addr_bits),
    .data_bits(data_bits),
    .max_out  (max_out)
  ) axi_read_xbar_inst (
    .clk(clk), .rstn(rstn),
    .m0_arid(m_arid[0]), .m0_araddr(m_araddr[0]), .m0_arlen(m_arlen[0]),
    .m0_arvalid(m_arvalid[0]), .m0_arready(m_arready[0]),
    .m0_rid(m_rid[0]), .m0_rdata(m_rdata[0]), .m0_rresp(m_rresp[0]),
    .m0_rlast(m_rlast[0]), .m0_rvalid(m_rvalid[0]), .m0_rready(m_rready[0]),
    .m1_arid(m_arid[1]), .m1_araddr(m_araddr[1]), .m1_arlen(m_arlen[1]),
    .m1_arvalid(m_arvalid[1]), .m1_arready(m_arready[1]),
    .m1_rid(m_rid[1]), .m1_rdata(m_rdata[1]), .m1_rresp(m_rresp[1]),
    .m1_rlast(m_rlast[1]), .m1_rvalid(m_rvalid[1]), .m1_rready(m_rready[1]),
    .s0_arid(s_arid[0]), .s0_araddr(s_araddr[0]), .s0_arlen(s_arlen[0]),
    .s0_arvalid(s_arvalid[0]), .s0_arready(s_arready[0]),
    .s0_rid(s_rid[0]), .s0_rdata(s_rdata[0]), .s0_rresp(s_rresp[0]),
    .s0_rlast(s_rlast[0]), .s0_rvalid(s_rvalid[0]), .s0_rready(s_rready[0]),
    .s1_arid(s_arid[1]), .s1_araddr(s_araddr[1]), .s1_arlen(s_arlen[1]),
    .s1_arvalid(s_arvalid[1]), .s1_arready(s_arready[1]),
    .s1_rid(s_rid[1]), .s1_rdata(s_rdata[1]), .s1_rresp(s_rresp[1]),
    .s1_rlast(s_rlast[1]), .s1_rvalid(s_rvalid[1]), .s1_rready(s_rready[1]),
    .s2_arid(s_arid[2]), .s2_araddr(s_araddr[2]), .s2_arlen(s_arlen[2]),
    .s2_arvalid(s_arvalid[2]), .s2_arready(s_arready[2]),
    .s2_rid(s_rid[2]), .s2_rdata(s_rdata[2]), .s2_rresp(s_rresp[2]),
    .s2_rlast(s_rlast[2]), .s2_rvalid(s_rvalid[2]), .s2_rready(s_rready[2])
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng >> 16;  // Low LCG bits repeat too soon
  endfunction

  task automatic load_table();
    // Columns are master, addr, len, expected slave; the row index is the ID
    rows[0]  = '{1'b0, 32'h0000_0010, 8'd0, 2'd0};
    rows[1]  = '{1'b0, 32'h0001_0020, 8'd0, 2'd1};
    rows[2]  = '{1'b0, 32'h0002_0030, 8'd0, 2'd2};
    rows[3]  = '{1'b0, 32'h0003_0040, 8'd0, 2'd2};  // Alias region
    rows[4]  = '{1'b1, 32'h0001_0100, 8'd3, 2'd1};
    rows[5]  = '{1'b1, 32'h0002_0200, 8'd7, 2'd2};
    rows[6]  = '{1'b0, 32'h0001_0300, 8'd3, 2'd1};
    rows[7]  = '{1'b1, 32'h0002_0400, 8'd5, 2'd2};
    rows[8]  = '{1'b0, 32'h0000_0500, 8'd1, 2'd0};
    rows[9]  = '{1'b1, 32'h0000_0600, 8'd2, 2'd0};
    rows[10] = '{1'b0, 32'h0000_0700, 8'd0, 2'd0};
    rows[11] = '{1'b1, 32'h0000_0800, 8'd1, 2'd0};
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    mismatches++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    failures++;
  endtask

  task automatic issue_rows(input int m);
    for (int r = 0; r < n_rows; r++) begin
      if (rows[r].master == m) begin
        @(negedge clk);
        m_arid[m]    = id_bits'(r);
        m_araddr[m]  = rows[r].addr;
        m_arlen[m]   = rows[r].len;
        m_arvalid[m] = 1'b1;
        @(posedge clk);
        while (!m_arready[m]) begin
          @(posedge clk);
        end
      end
    end
    @(negedge clk);
    m_arvalid[m] = 1'b0;
  endtask

  task automatic check_ar(input int s);
    int r;
    r = s_arid[s][id_bits-1:0];
    if (r >= n_rows) begin
      report_failure($sformatf("slave %0d got an AR with unknown ID %0d", s, r));
    end else begin
      if (s != rows[r].slave) begin
        report_mismatch($sformatf("ID %0d decoded to slave %0d, expected %0d",
                                  r, s, rows[r].slave));
      end
      if (s_arid[s][tid_bits-1 -: tag_bits] != rows[r].master) begin
        report_mismatch($sformatf("ID %0d carries tag %0d", r,
                                  s_arid[s][tid_bits-1 -: tag_bits]));
      end
      if (s_araddr[s] != rows[r].addr || s_arlen[s] != rows[r].len) begin
        report_mismatch($sformatf("ID %0d addr or len changed on the way", r));
      end
    end
  endtask

  task automatic check_master(input int m);
    int          r;
    int          b;
    logic [31:0] exp_data;
    if (held[m]) begin
      if (!m_rvalid[m] || m_rid[m] != held_id[m] || m_rdata[m] != held_data[m]) begin
        report_mismatch($sformatf("master %0d beat changed while stalled", m));
      end
    end
    held[m]      = m_rvalid[m] && !m_rready[m];
    held_id[m]   = m_rid[m];
    held_data[m] = m_rdata[m];
    if (m_rvalid[m] && m_rready[m]) begin
      r = m_rid[m];
      if (r >= n_rows || rows[r].master != m) begin
        report_mismatch($sformatf("master %0d got a beat for ID %0d", m, r));
      end else begin
        b        = beats_got[r];
        exp_data = {rows[r].slave, 30'(rows[r].addr + b)};
        if (b > rows[r].len) begin
          report_mismatch($sformatf("ID %0d got extra beat %0d", r, b));
        end else begin
          if (m_rdata[m] != exp_data) begin
            report_mismatch($sformatf("ID %0d beat %0d data %h, expected %h",
                                      r, b, m_rdata[m], exp_data));
          end
          if (m_rresp[m] != 2'b00) begin
            report_mismatch($sformatf("ID %0d beat %0d resp %0d", r, b, m_rresp[m]));
          end
          if (m_rlast[m] != (b == rows[r].len)) begin
            report_mismatch($sformatf("ID %0d beat %0d rlast %0b", r, b, m_rlast[m]));
          end
        end
        beats_got[r]++;
        beats_done++;
      end
    end
  endtask

  task automatic sample_edge();
    for (int s = 0; s < 3; s++) begin
      if (s_rvalid[s] && s_rready[s]) begin
        r_taken[s] = 1'b1;
        if (s_rlast[s]) begin
          rd_ptr[s]++;
          beat_no[s]   = 0;
          open_cnt[s]--;
        end else begin
          beat_no[s]++;
        end
      end
      if (s_arvalid[s] && s_arready[s]) begin
        check_ar(s);
        fifo[s][wr_ptr[s] % 16] = {s_arid[s], s_araddr[s], s_arlen[s]};
        wr_ptr[s]++;
        open_cnt[s]++;
      end
      if (open_cnt[s] > max_out) begin
        report_failure($sformatf("slave %0d has %0d open bursts, over the limit",
                                 s, open_cnt[s]));
      end
    end
    if (open_cnt[0] > max_open0) begin
      max_open0 = open_cnt[0];
    end
    check_master(0);
    check_master(1);
  endtask

  task automatic present_beat(input int s);
    logic [45:0] e;
    logic        idle;
    e    = fifo[s][rd_ptr[s] % 16];
    idle = (next_rand() % 4) == 0;
    if (rd_ptr[s] != wr_ptr[s] && !(s == 0 && cycle < hold_cycles) && !idle) begin
      s_rid[s]    = e[45:40];
      s_rdata[s]  = {2'(s), 30'(e[39:8] + beat_no[s])};
      s_rresp[s]  = 2'b00;
      s_rlast[s]  = (beat_no[s] == e[7:0]);
      s_rvalid[s] = 1'b1;
    end else begin
      s_rvalid[s] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > limit) begin
      $display("Timeout after %0d cycles, %0d of %0d beats received",
               cycle, beats_done, total_beats);
      $display("TEST FAILED");
      $finish;
    end else begin
      sample_edge();
    end
  end

  // Slave and master responses change on the falling edge
  always @(negedge clk) begin
    for (int s = 0; s < 3; s++) begin
      s_arready[s] = (next_rand() % 4) != 0;
      if (!(s_rvalid[s] && !r_taken[s])) begin
        present_beat(s);
      end
      r_taken[s] = 1'b0;
    end
    for (int m = 0; m < 2; m++) begin
      m_rready[m] = (next_rand() % 3) != 0;
    end
  end

  initial begin
    rng         = 32'h49d1;
    mismatches  = 0;
    failures    = 0;
    cycle       = 0;
    beats_done  = 0;
    total_beats = 0;
    max_open0   = 0;
    for (int m = 0; m < 2; m++) begin
      m_arid[m]    = '0;
      m_araddr[m]  = '0;
      m_arlen[m]   = '0;
      m_arvalid[m] = 1'b0;
      m_rready[m]  = 1'b0;
      held[m]      = 1'b0;
    end
    for (int s = 0; s < 3; s++) begin
      s_arready[s] = 1'b0;
      s_rid[s]     = '0;
      s_rdata[s]   = '0;
      s_rresp[s]   = 2'b00;
      s_rlast[s]   = 1'b0;
      s_rvalid[s]  = 1'b0;
      wr_ptr[s]    = 0;
      rd_ptr[s]    = 0;
      beat_no[s]   = 0;
      open_cnt[s]  = 0;
      r_taken[s]   = 1'b0;
    end
    load_table();
    for (int r = 0; r < n_rows; r++) begin
      beats_got[r] = 0;
      total_beats += rows[r].len + 1;
    end
    limit = total_beats * 40 + 200;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    fork
      issue_rows(0);
      issue_rows(1);
    join
    wait (beats_done >= total_beats);
    repeat (4) @(posedge clk);

    for (int r = 0; r < n_rows; r++) begin
      if (beats_got[r] != rows[r].len + 1) begin
        report_failure($sformatf("ID %0d got %0d beats instead of %0d",
                                 r, beats_got[r], rows[r].len + 1));
      end
    end
    if (max_open0 != max_out) begin
      report_failure("slave 0 never reached its limit of open bursts");
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
